// File: src/board_ctrl_pkg.sv
`default_nettype none

package board_ctrl_pkg;

    ////////////////////
    // register port types
    ////////////////////

    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // health event counters, read back one byte at a time
    typedef logic [31:0] event_count_t;

    ////////////////////
    // register map
    ////////////////////

    localparam reg_addr_t addr_led_mode      = 8'h00;
    localparam reg_addr_t addr_command       = 8'h01;
    localparam reg_addr_t addr_status        = 8'h02;

    // base of each four-byte counter window, byte 0 is the lsb
    localparam reg_addr_t addr_main_lockloss = 8'h10;
    localparam reg_addr_t addr_hdmi_lockloss = 8'h14;
    localparam reg_addr_t addr_resync        = 8'h18;

    // command byte bits, self clearing
    localparam int cmd_console_reset = 0;
    localparam int cmd_drive_reset   = 1;

    // status byte bits
    localparam int stat_console_reset = 0;
    localparam int stat_drive_reset   = 1;
    localparam int stat_hdmi_ready    = 2;

endpackage

`default_nettype wire

// File: src/status_led_pkg.sv
`default_nettype none

package status_led_pkg;

    // mode register values
    typedef enum logic [1:0] {
        led_health         = 2'd0,
        led_follow_drive   = 2'd1,
        led_follow_console = 2'd2,
        led_off            = 2'd3
    } led_mode_e;

    // health pattern chosen by the priority chain
    typedef enum logic [2:0] {
        pat_dim        = 3'd0,
        pat_fast_glow  = 3'd1,
        pat_blink_glow = 3'd2,
        pat_steady     = 3'd3,
        pat_slow_glow  = 3'd4
    } led_pattern_e;

endpackage

`default_nettype wire

// File: src/ctrl_regs.sv
`timescale 1ns/100ps
`default_nettype none

module ctrl_regs (
    input  wire                         control_clock,
    input  wire                         reset_dc,
    input  wire                         wr_en,
    input  board_ctrl_pkg::reg_addr_t   wr_addr,
    input  board_ctrl_pkg::reg_data_t   wr_data,
    input  board_ctrl_pkg::reg_addr_t   rd_addr,
    input  board_ctrl_pkg::event_count_t main_lockloss_count,
    input  board_ctrl_pkg::event_count_t hdmi_lockloss_count,
    input  board_ctrl_pkg::event_count_t resync_count,
    input  wire                         console_reset_low,
    input  wire                         drive_reset_low,
    input  wire                         hdmi_ready,
    output board_ctrl_pkg::reg_data_t   rd_data,
    output status_led_pkg::led_mode_e   led_mode,
    output logic                        console_reset_req,
    output logic                        drive_reset_req
);

    import board_ctrl_pkg::*;
    import status_led_pkg::*;

    reg_data_t status_byte;
    reg_data_t read_mux;
    logic      cmd_write;

    // pick one byte of a counter, little endian
    function automatic reg_data_t count_byte(input event_count_t count, input logic [1:0] sel);
        return count[{sel, 3'b000} +: 8];
    endfunction

    assign cmd_write = wr_en && (wr_addr == addr_command);

    ////////////////////
    // write side
    ////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            led_mode          <= led_health;
            console_reset_req <= 1'b0;
            drive_reset_req   <= 1'b0;
        end else begin
            if (wr_en && (wr_addr == addr_led_mode)) begin
                led_mode <= led_mode_e'(wr_data[1:0]);
            end
            // one cycle pulses, nothing stored
            console_reset_req <= cmd_write && wr_data[cmd_console_reset];
            drive_reset_req   <= cmd_write && wr_data[cmd_drive_reset];
        end
    end

    ////////////////////
    // read side
    ////////////////////

    always_comb begin
        status_byte                     = '0;
        status_byte[stat_console_reset] = console_reset_low;
        status_byte[stat_drive_reset]   = drive_reset_low;
        status_byte[stat_hdmi_ready]    = hdmi_ready;
    end

    always_comb begin
        read_mux = '0;
        if (rd_addr == addr_led_mode) begin
            read_mux = reg_data_t'(led_mode);
        end else if (rd_addr == addr_status) begin
            read_mux = status_byte;
        end else if (rd_addr[7:2] == addr_main_lockloss[7:2]) begin
            read_mux = count_byte(main_lockloss_count, rd_addr[1:0]);
        end else if (rd_addr[7:2] == addr_hdmi_lockloss[7:2]) begin
            read_mux = count_byte(hdmi_lockloss_count, rd_addr[1:0]);
        end else if (rd_addr[7:2] == addr_resync[7:2]) begin
            read_mux = count_byte(resync_count, rd_addr[1:0]);
        end
    end

    always_ff @(posedge control_clock) begin
        rd_data <= read_mux;
    end

endmodule

`default_nettype wire

// File: src/reset_hold_timer.sv
`timescale 1ns/100ps
`default_nettype none

module reset_hold_timer #(
    parameter int reset_hold_cycles = 32_000_000
) (
    input  wire  control_clock,
    input  wire  reset_dc,
    input  wire  request,
    output logic reset_low
);

    localparam int cnt_w = $clog2(reset_hold_cycles + 1) + 1;

    typedef logic [cnt_w-1:0] hold_count_t;

    hold_count_t hold_count;

    // line held for reset_hold_cycles+1 cycles after the last request
    always_ff @(posedge control_clock) begin
        if (reset_dc || request) begin
            hold_count <= '0;
            reset_low  <= 1'b1;
        end else if (reset_low) begin
            if (hold_count == hold_count_t'(reset_hold_cycles)) begin
                reset_low <= 1'b0;
            end else begin
                hold_count <= hold_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/led_pattern_gen.sv
`timescale 1ns/100ps
`default_nettype none

module led_pattern_gen #(
    parameter int slow_glow_bit = 26,
    parameter int fast_glow_bit = 22,
    parameter int blink_bit     = 24
) (
    input  wire  control_clock,
    input  wire  reset_dc,
    output logic dim,
    output logic slow_glow,
    output logic fast_glow,
    output logic blink
);

    localparam int glow_top = (slow_glow_bit > fast_glow_bit) ? slow_glow_bit : fast_glow_bit;
    localparam int top_bit  = (glow_top > blink_bit) ? glow_top : blink_bit;
    // low byte is always needed for the pwm compare
    localparam int cnt_w    = (top_bit + 1 > 8) ? top_bit + 1 : 8;

    typedef logic [cnt_w-1:0] pattern_count_t;

    pattern_count_t pattern_count;

    // bit_pos picks the ramp direction, the bits below it give the ramp
    function automatic logic glow_pwm(input pattern_count_t cnt, input int bit_pos);
        pattern_count_t shifted;
        logic [7:0]     ramp;
        if (bit_pos >= 8) begin
            shifted = cnt >> (bit_pos - 8);
        end else begin
            shifted = cnt << (8 - bit_pos);
        end
        ramp = shifted[7:0];
        if (cnt[bit_pos]) begin
            ramp = ~ramp;
        end
        return cnt[7:0] < ramp;
    endfunction

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            pattern_count <= '0;
        end else begin
            pattern_count <= pattern_count + 1'b1;
        end
    end

    // quarter duty
    assign dim       = (pattern_count[1:0] == 2'b00);
    assign slow_glow = glow_pwm(pattern_count, slow_glow_bit);
    assign fast_glow = glow_pwm(pattern_count, fast_glow_bit);
    assign blink     = pattern_count[blink_bit];

endmodule

`default_nettype wire

// File: src/status_led_mux.sv
`timescale 1ns/100ps
`default_nettype none

module status_led_mux (
    input  wire                       control_clock,
    input  wire                       reset_dc,
    input  status_led_pkg::led_mode_e led_mode,
    input  wire                       hdmi_ready,
    input  wire                       resync_seen,
    input  wire                       force_generate,
    input  wire                       link_ready,
    input  wire                       dim,
    input  wire                       slow_glow,
    input  wire                       fast_glow,
    input  wire                       blink,
    input  wire                       console_reset_low,
    input  wire                       drive_reset_low,
    output logic                      status_led_oe,
    output logic                      status_led_level
);

    import status_led_pkg::*;

    led_pattern_e health_pattern;
    logic         health_level;

    // health priority, first match wins
    always_comb begin
        if (!hdmi_ready) begin
            health_pattern = pat_dim;
        end else if (resync_seen) begin
            health_pattern = pat_fast_glow;
        end else if (force_generate) begin
            health_pattern = pat_blink_glow;
        end else if (link_ready) begin
            health_pattern = pat_steady;
        end else begin
            health_pattern = pat_slow_glow;
        end
    end

    // led is active low
    always_comb begin
        case (health_pattern)
            pat_dim:        health_level = ~dim;
            pat_fast_glow:  health_level = ~fast_glow;
            pat_blink_glow: health_level = blink ? ~fast_glow : 1'b1;
            pat_steady:     health_level = 1'b0;
            default:        health_level = ~slow_glow;
        endcase
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            status_led_oe    <= 1'b0;
            status_led_level <= 1'b1;
        end else begin
            case (led_mode)
                led_health: begin
                    status_led_oe    <= 1'b1;
                    status_led_level <= health_level;
                end
                led_follow_drive: begin
                    status_led_oe    <= drive_reset_low;
                    status_led_level <= 1'b0;
                end
                led_follow_console: begin
                    status_led_oe    <= console_reset_low;
                    status_led_level <= 1'b0;
                end
                default: begin
                    status_led_oe    <= 1'b0;
                    status_led_level <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/health_counters.sv
`timescale 1ns/100ps
`default_nettype none

module health_counters (
    input  wire                          control_clock,
    input  wire                          reset_dc,
    input  wire                          pll_main_locked,
    input  wire                          pll_hdmi_locked,
    input  wire                          resync,
    output logic                         hdmi_ready,
    output logic                         resync_seen,
    output board_ctrl_pkg::event_count_t main_lockloss_count,
    output board_ctrl_pkg::event_count_t hdmi_lockloss_count,
    output board_ctrl_pkg::event_count_t resync_count
);

    import board_ctrl_pkg::*;

    localparam int idx_main   = 0;
    localparam int idx_hdmi   = 1;
    localparam int idx_resync = 2;

    logic [2:0]   async_in;
    logic [2:0]   sync_meta;
    logic [2:0]   sync_q;
    logic [2:0]   sync_d;
    logic [2:0]   event_pulse;
    event_count_t event_count [3];

    assign async_in = {resync, pll_hdmi_locked, pll_main_locked};

    ////////////////////
    // sync and edge detect
    ////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            sync_meta   <= '0;
            sync_q      <= '0;
            sync_d      <= '0;
            event_pulse <= '0;
        end else begin
            sync_meta <= async_in;
            sync_q    <= sync_meta;
            sync_d    <= sync_q;
            // lock loss is a falling edge, resync a rising one
            event_pulse[idx_main]   <= sync_d[idx_main] & ~sync_q[idx_main];
            event_pulse[idx_hdmi]   <= sync_d[idx_hdmi] & ~sync_q[idx_hdmi];
            event_pulse[idx_resync] <= ~sync_d[idx_resync] & sync_q[idx_resync];
        end
    end

    always_ff @(posedge control_clock) begin
        for (int i = 0; i < 3; i++) begin
            if (reset_dc) begin
                event_count[i] <= '0;
            end else if (event_pulse[i]) begin
                event_count[i] <= event_count[i] + 1'b1;
            end
        end
    end

    assign hdmi_ready          = sync_q[idx_hdmi];
    assign resync_seen         = sync_q[idx_resync];
    assign main_lockloss_count = event_count[idx_main];
    assign hdmi_lockloss_count = event_count[idx_hdmi];
    assign resync_count        = event_count[idx_resync];

endmodule

`default_nettype wire

// File: src/board_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module board_ctrl_top #(
    parameter int reset_hold_cycles = 32_000_000,
    parameter int slow_glow_bit     = 26,
    parameter int fast_glow_bit     = 22,
    parameter int blink_bit         = 24
) (
    input  wire                       control_clock,
    input  wire                       reset_dc,
    input  wire                       wr_en,
    input  board_ctrl_pkg::reg_addr_t wr_addr,
    input  board_ctrl_pkg::reg_data_t wr_data,
    input  board_ctrl_pkg::reg_addr_t rd_addr,
    input  wire                       pll_main_locked,
    input  wire                       pll_hdmi_locked,
    input  wire                       resync,
    input  wire                       force_generate,
    input  wire                       link_ready,
    output board_ctrl_pkg::reg_data_t rd_data,
    output wire                       console_reset_low,
    output wire                       drive_reset_low,
    output wire                       status_led_oe,
    output wire                       status_led_level
);

    import board_ctrl_pkg::*;
    import status_led_pkg::*;

    led_mode_e    led_mode;
    event_count_t main_lockloss_count;
    event_count_t hdmi_lockloss_count;
    event_count_t resync_count;
    wire          console_reset_req;
    wire          drive_reset_req;
    wire          hdmi_ready;
    wire          resync_seen;
    wire          dim;
    wire          slow_glow;
    wire          fast_glow;
    wire          blink;

    ctrl_regs ctrl_regs_i (
        .control_clock       (control_clock),
        .reset_dc            (reset_dc),
        .wr_en               (wr_en),
        .wr_addr             (wr_addr),
        .wr_data             (wr_data),
        .rd_addr             (rd_addr),
        .main_lockloss_count (main_lockloss_count),
        .hdmi_lockloss_count (hdmi_lockloss_count),
        .resync_count        (resync_count),
        .console_reset_low   (console_reset_low),
        .drive_reset_low     (drive_reset_low),
        .hdmi_ready          (hdmi_ready),
        .rd_data             (rd_data),
        .led_mode            (led_mode),
        .console_reset_req   (console_reset_req),
        .drive_reset_req     (drive_reset_req)
    );

    ////////////////////
    // console and drive reset lines
    ////////////////////

    reset_hold_timer #(
        .reset_hold_cycles (reset_hold_cycles)
    ) console_timer (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .request       (console_reset_req),
        .reset_low     (console_reset_low)
    );

    reset_hold_timer #(
        .reset_hold_cycles (reset_hold_cycles)
    ) drive_timer (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .request       (drive_reset_req),
        .reset_low     (drive_reset_low)
    );

    ////////////////////
    // status led
    ////////////////////

    led_pattern_gen #(
        .slow_glow_bit (slow_glow_bit),
        .fast_glow_bit (fast_glow_bit),
        .blink_bit     (blink_bit)
    ) led_pattern_gen_i (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .dim           (dim),
        .slow_glow     (slow_glow),
        .fast_glow     (fast_glow),
        .blink         (blink)
    );

    status_led_mux status_led_mux_i (
        .control_clock     (control_clock),
        .reset_dc          (reset_dc),
        .led_mode          (led_mode),
        .hdmi_ready        (hdmi_ready),
        .resync_seen       (resync_seen),
        .force_generate    (force_generate),
        .link_ready        (link_ready),
        .dim               (dim),
        .slow_glow         (slow_glow),
        .fast_glow         (fast_glow),
        .blink             (blink),
        .console_reset_low (console_reset_low),
        .drive_reset_low   (drive_reset_low),
        .status_led_oe     (status_led_oe),
        .status_led_level  (status_led_level)
    );

    health_counters health_counters_i (
        .control_clock       (control_clock),
        .reset_dc            (reset_dc),
        .pll_main_locked     (pll_main_locked),
        .pll_hdmi_locked     (pll_hdmi_locked),
        .resync              (resync),
        .hdmi_ready          (hdmi_ready),
        .resync_seen         (resync_seen),
        .main_lockloss_count (main_lockloss_count),
        .hdmi_lockloss_count (hdmi_lockloss_count),
        .resync_count        (resync_count)
    );

endmodule

`default_nettype wire

// File: tb/board_ctrl_tb.sv
`timescale 1ns/100ps
`default_nettype none

module board_ctrl_tb;

    import board_ctrl_pkg::*;
    import status_led_pkg::*;

    localparam int hold_cycles = 40;
    // a few hold windows plus the pulse tests with a wide margin
    localparam int watchdog_cycles = 400 * (hold_cycles + 10);

    logic         control_clock;
    logic         reset_dc;
    logic         wr_en;
    reg_addr_t    wr_addr;
    reg_data_t    wr_data;
    reg_addr_t    rd_addr;
    logic         pll_main_locked;
    logic         pll_hdmi_locked;
    logic         resync;
    logic         force_generate;
    logic         link_ready;
    reg_data_t    rd_data;
    wire          console_reset_low;
    wire          drive_reset_low;
    wire          status_led_oe;
    wire          status_led_level;

    logic [31:0]  lfsr_state;
    int           checks;
    int           errors;

    board_ctrl_top #(
        .reset_hold_cycles (hold_cycles),
        .slow_glow_bit     (9),
        .fast_glow_bit     (5),
        .blink_bit         (6)
    ) board_ctrl_top_i (
        .control_clock     (control_clock),
        .reset_dc          (reset_dc),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .rd_addr           (rd_addr),
        .pll_main_locked   (pll_main_locked),
        .pll_hdmi_locked   (pll_hdmi_locked),
        .resync            (resync),
        .force_generate    (force_generate),
        .link_ready        (link_ready),
        .rd_data           (rd_data),
        .console_reset_low (console_reset_low),
        .drive_reset_low   (drive_reset_low),
        .status_led_oe     (status_led_oe),
        .status_led_level  (status_led_level)
    );

    initial begin
        control_clock = 1'b0;
        forever #5 control_clock = ~control_clock;
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic expect_true(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s", $time, msg);
        end
    endtask

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int width, output int value);
        value = 0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(posedge control_clock);
        #1;
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(posedge control_clock);
        #1 wr_en = 1'b0;
    endtask

    // read data is registered so it is sampled one cycle after the address
    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        @(posedge control_clock);
        #1 rd_addr = addr;
        @(posedge control_clock);
        @(negedge control_clock);
        data = rd_data;
    endtask

    task automatic read_count(input reg_addr_t base, output event_count_t value);
        reg_data_t data;
        for (int b = 0; b < 4; b++) begin
            read_reg(base + reg_addr_t'(b), data);
            value[8*b +: 8] = data;
        end
    endtask

    task automatic command_window_check(input int cmd_bit, input string name);
        logic chosen;
        logic other;
        logic expect_low;
        write_reg(addr_command, reg_data_t'(1 << cmd_bit));
        for (int i = 0; i <= hold_cycles + 3; i++) begin
            @(negedge control_clock);
            chosen = (cmd_bit == cmd_console_reset) ? console_reset_low : drive_reset_low;
            other  = (cmd_bit == cmd_console_reset) ? drive_reset_low : console_reset_low;
            expect_low = (i >= 1) && (i <= hold_cycles + 1);
            expect_true(chosen == expect_low && other == 1'b0,
                $sformatf("%s line cycle %0d: %b, expected %b", name, i, chosen, expect_low));
        end
    endtask

    // which selects 0 main lock drop, 1 hdmi lock drop or 2 resync pulse
    task automatic set_event_input(input int which, input logic active);
        case (which)
            0: pll_main_locked = ~active;
            1: pll_hdmi_locked = ~active;
            default: resync = active;
        endcase
    endtask

    task automatic count_events(input int which, input reg_addr_t base, input string name);
        int           n;
        int           active_len;
        int           idle_len;
        event_count_t count;
        random_bits(3, n);
        n = (n % 7) + 1;
        for (int p = 0; p < n; p++) begin
            random_bits(2, active_len);
            random_bits(2, idle_len);
            @(posedge control_clock);
            #1 set_event_input(which, 1'b1);
            repeat (active_len + 1) @(posedge control_clock);
            #1 set_event_input(which, 1'b0);
            repeat (idle_len + 1) @(posedge control_clock);
        end
        repeat (8) @(posedge control_clock);
        read_count(base, count);
        expect_true(count == event_count_t'(n),
            $sformatf("%s count %0d, expected %0d", name, count, n));
    endtask

    task automatic follow_mode_check(input led_mode_e mode, input int cmd_bit, input string name);
        write_reg(addr_led_mode, reg_data_t'(mode));
        repeat (2) @(posedge control_clock);
        @(negedge control_clock);
        expect_true(status_led_oe == 1'b0, $sformatf("%s: oe set with line idle", name));
        write_reg(addr_command, reg_data_t'(1 << cmd_bit));
        repeat (3) @(posedge control_clock);
        repeat (16) begin
            @(negedge control_clock);
            expect_true(status_led_oe == 1'b1 && status_led_level == 1'b0,
                $sformatf("%s: oe %b level %b during hold", name, status_led_oe,
                    status_led_level));
        end
        repeat (hold_cycles + 4) @(posedge control_clock);
        @(negedge control_clock);
        expect_true(status_led_oe == 1'b0, $sformatf("%s: oe still set after release", name));
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        reg_data_t data;
        int        low_count;
        lfsr_state      = 32'hf64f_07d3;
        checks          = 0;
        errors          = 0;
        reset_dc        = 1'b1;
        wr_en           = 1'b0;
        wr_addr         = '0;
        wr_data         = '0;
        rd_addr         = '0;
        pll_main_locked = 1'b1;
        pll_hdmi_locked = 1'b1;
        resync          = 1'b0;
        force_generate  = 1'b0;
        link_ready      = 1'b0;

        repeat (8) @(posedge control_clock);
        #1 reset_dc = 1'b0;
        for (int i = 0; i <= hold_cycles + 3; i++) begin
            @(negedge control_clock);
            expect_true(console_reset_low == (i <= hold_cycles) &&
                drive_reset_low == (i <= hold_cycles),
                $sformatf("reset release cycle %0d: console %b drive %b", i,
                    console_reset_low, drive_reset_low));
        end

        command_window_check(cmd_console_reset, "console");
        command_window_check(cmd_drive_reset, "drive");

        // status byte while each line is held and after release
        write_reg(addr_command, reg_data_t'(1 << cmd_console_reset));
        repeat (4) @(posedge control_clock);
        read_reg(addr_status, data);
        expect_true(data == 8'h05, $sformatf("status during console hold %h", data));
        repeat (hold_cycles + 4) @(posedge control_clock);
        read_reg(addr_status, data);
        expect_true(data == 8'h04, $sformatf("status after console release %h", data));
        write_reg(addr_command, reg_data_t'(1 << cmd_drive_reset));
        repeat (4) @(posedge control_clock);
        read_reg(addr_status, data);
        expect_true(data == 8'h06, $sformatf("status during drive hold %h", data));
        repeat (hold_cycles + 4) @(posedge control_clock);
        read_reg(addr_status, data);
        expect_true(data == 8'h04, $sformatf("status after drive release %h", data));
        read_reg(8'h30, data);
        expect_true(data == 8'h00, $sformatf("unmapped address read %h", data));

        count_events(0, addr_main_lockloss, "main lock loss");
        count_events(1, addr_hdmi_lockloss, "hdmi lock loss");
        count_events(2, addr_resync, "resync");

        write_reg(addr_led_mode, reg_data_t'(led_off));
        repeat (2) @(posedge control_clock);
        repeat (8) begin
            @(negedge control_clock);
            expect_true(status_led_oe == 1'b0, "led off mode drives oe");
        end
        follow_mode_check(led_follow_console, cmd_console_reset, "follow console");
        follow_mode_check(led_follow_drive, cmd_drive_reset, "follow drive");

        write_reg(addr_led_mode, reg_data_t'(led_health));
        #1 link_ready = 1'b1;
        repeat (3) @(posedge control_clock);
        repeat (16) begin
            @(negedge control_clock);
            expect_true(status_led_oe == 1'b1 && status_led_level == 1'b0,
                "steady health pattern not lit");
        end

        // unlocked hdmi pll shows the dim pattern
        @(posedge control_clock);
        #1 pll_hdmi_locked = 1'b0;
        repeat (8) @(posedge control_clock);
        low_count = 0;
        repeat (64) begin
            @(negedge control_clock);
            if (status_led_level == 1'b0) begin
                low_count++;
            end
        end
        expect_true(low_count == 16, $sformatf("dim duty %0d of 64, expected 16", low_count));

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge control_clock);
        $display("watchdog expired after %0d cycles, the test did not finish", watchdog_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
src/board_ctrl_pkg.sv
src/status_led_pkg.sv
src/ctrl_regs.sv
src/reset_hold_timer.sv
src/led_pattern_gen.sv
src/status_led_mux.sv
src/health_counters.sv
src/board_ctrl_top.sv
tb/board_ctrl_tb.sv

// File: Bender.yml
package:
  name: board_ctrl

sources:
  # packages
  - src/board_ctrl_pkg.sv
  - src/status_led_pkg.sv
  # rtl
  - src/ctrl_regs.sv
  - src/reset_hold_timer.sv
  - src/led_pattern_gen.sv
  - src/status_led_mux.sv
  - src/health_counters.sv
  - src/board_ctrl_top.sv
  # testbench
  - target: simulation
    files:
      - tb/board_ctrl_tb.sv
